//--- rtl/rv_ctrl_pkg.sv
// Shared widths, RV32I opcodes, control encodings and control bundles for the rv_ctrl pipeline
package rv_ctrl_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] instr_t;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_imm    = 7'b0010011,
    op_auipc  = 7'b0010111,
    op_store  = 7'b0100011,
    op_r      = 7'b0110011,
    op_lui    = 7'b0110111,
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9
  } alu_op_t;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_fmt_t;

  typedef enum logic {a_rs1, a_pc} a_sel_t;
  typedef enum logic {b_rs2, b_imm} b_sel_t;

  typedef enum logic [1:0] {
    wb_none, wb_alu, wb_mem, wb_pc_plus4
  } wb_sel_t;

  // Load extension, word must stay at zero
  typedef enum logic [2:0] {
    ldx_word, ldx_hu, ldx_hs, ldx_bu, ldx_bs
  } ldx_t;

  typedef enum logic {pc_seq, pc_alu} pc_sel_t;

  typedef enum logic [1:0] {br_none, br_branch, br_jump} br_kind_t;

  // Branch condition funct3 codes
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // Writeback controls, all zero is a bubble
  typedef struct packed {
    logic    rf_we;
    wb_sel_t wb_sel;
    ldx_t    ldx;
  } w_ctrl_t;

  // Execute controls plus the writeback bundle riding along
  typedef struct packed {
    alu_op_t  alu_op;
    a_sel_t   a_sel;
    b_sel_t   b_sel;
    imm_fmt_t imm_fmt;
    logic     br_un;
    br_kind_t br_kind;
    logic [2:0] funct3;   // Branch condition
    w_ctrl_t  w;
  } x_ctrl_t;

endpackage

//--- rtl/pipe_slot.sv
// One pipeline register entry with valid, hold and kill, instantiated per slot with its payload type
`timescale 1ns/10ps

module pipe_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_payload,
  input  logic     hold,
  input  logic     kill,
  output logic     out_valid,
  output payload_t out_payload
);

  payload_t next_payload;

  // Invalid entries always carry a zero payload
  assign next_payload = in_valid ? in_payload : payload_t'('0);

  always_ff @(posedge clk) begin
    if (rst || kill) begin
      out_valid   <= 1'b0;          // Bubble
      out_payload <= payload_t'('0);
    end else if (!hold) begin
      out_valid   <= in_valid;
      out_payload <= next_payload;
    end
  end

endmodule

//--- rtl/instr_decoder.sv
// Combinational RV32I decoder that turns one instruction word into the execute control bundle
`timescale 1ns/10ps

module instr_decoder (
  input  rv_ctrl_pkg::instr_t  instr,
  output rv_ctrl_pkg::x_ctrl_t ctrl
);

  import rv_ctrl_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       bit30;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign bit30  = instr[30];

  // ALU operation from funct3, alt selects sub or sra
  function automatic alu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;                          // Unknown opcode stays a bubble
    case (opcode)
      op_r: begin
        ctrl.alu_op   = alu_op_of(funct3, bit30);
        ctrl.w.rf_we  = 1'b1;
        ctrl.w.wb_sel = wb_alu;
      end
      op_imm: begin
        // Bit 30 is part of the immediate except on shift right
        ctrl.alu_op   = alu_op_of(funct3, bit30 && (funct3 == 3'b101));
        ctrl.b_sel    = b_imm;
        ctrl.imm_fmt  = imm_i;
        ctrl.w.rf_we  = 1'b1;
        ctrl.w.wb_sel = wb_alu;
      end
      op_load: begin
        ctrl.alu_op   = alu_add;        // Address rs1 + imm
        ctrl.b_sel    = b_imm;
        ctrl.imm_fmt  = imm_i;
        ctrl.w.rf_we  = 1'b1;
        ctrl.w.wb_sel = wb_mem;
        case (funct3)
          3'b000:  ctrl.w.ldx = ldx_bs;  // lb
          3'b001:  ctrl.w.ldx = ldx_hs;  // lh
          3'b100:  ctrl.w.ldx = ldx_bu;  // lbu
          3'b101:  ctrl.w.ldx = ldx_hu;  // lhu
          default: ctrl.w.ldx = ldx_word;
        endcase
      end
      op_store: begin
        ctrl.alu_op  = alu_add;
        ctrl.b_sel   = b_imm;
        ctrl.imm_fmt = imm_s;
      end
      op_branch: begin
        ctrl.alu_op  = alu_add;         // Target pc + imm
        ctrl.a_sel   = a_pc;
        ctrl.b_sel   = b_imm;
        ctrl.imm_fmt = imm_b;
        ctrl.br_un   = (funct3 == f3_bltu) || (funct3 == f3_bgeu);
        ctrl.br_kind = br_branch;
        ctrl.funct3  = funct3;
      end
      op_jal: begin
        ctrl.alu_op   = alu_add;
        ctrl.a_sel    = a_pc;
        ctrl.b_sel    = b_imm;
        ctrl.imm_fmt  = imm_j;
        ctrl.br_kind  = br_jump;
        ctrl.w.rf_we  = 1'b1;
        ctrl.w.wb_sel = wb_pc_plus4;    // Link address
      end
      op_jalr: begin
        ctrl.alu_op   = alu_add;        // Target rs1 + imm
        ctrl.b_sel    = b_imm;
        ctrl.imm_fmt  = imm_i;
        ctrl.br_kind  = br_jump;
        ctrl.w.rf_we  = 1'b1;
        ctrl.w.wb_sel = wb_pc_plus4;
      end
      op_auipc: begin
        ctrl.alu_op   = alu_add;
        ctrl.a_sel    = a_pc;
        ctrl.b_sel    = b_imm;
        ctrl.imm_fmt  = imm_u;
        ctrl.w.rf_we  = 1'b1;
        ctrl.w.wb_sel = wb_alu;
      end
      op_lui: begin
        // Datapath reads x0 on operand A for the U format, so result is imm
        ctrl.alu_op   = alu_add;
        ctrl.b_sel    = b_imm;
        ctrl.imm_fmt  = imm_u;
        ctrl.w.rf_we  = 1'b1;
        ctrl.w.wb_sel = wb_alu;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

//--- rtl/branch_resolver.sv
// Resolves branches and jumps in the execute slot into a next-pc select and a kill of younger slots
`timescale 1ns/10ps

module branch_resolver (
  input  logic                 x_valid,
  input  rv_ctrl_pkg::x_ctrl_t x_ctrl,
  input  logic                 br_eq,
  input  logic                 br_lt,   // Signed or unsigned per br_un
  input  logic                 stall,
  output rv_ctrl_pkg::pc_sel_t pc_sel,
  output logic                 kill
);

  import rv_ctrl_pkg::*;

  logic cond_true;
  logic redirect;

  always_comb begin
    case (x_ctrl.funct3)
      f3_beq:  cond_true = br_eq;
      f3_bne:  cond_true = !br_eq;
      f3_blt,
      f3_bltu: cond_true = br_lt;
      f3_bge,
      f3_bgeu: cond_true = !br_lt;
      default: cond_true = 1'b0;       // Reserved encodings never taken
    endcase
  end

  // Redirect waits for the first unstalled cycle
  always_comb begin
    redirect = 1'b0;
    if (x_valid && !stall) begin
      case (x_ctrl.br_kind)
        br_jump:   redirect = 1'b1;
        br_branch: redirect = cond_true;
        default:   redirect = 1'b0;
      endcase
    end
  end

  assign pc_sel = redirect ? pc_alu : pc_seq;
  assign kill   = redirect;

endmodule

//--- rtl/rv_ctrl_top.sv
// Top of the three-slot RV32I control path, connect to the datapath through its plain ports
`timescale 1ns/10ps

module rv_ctrl_top (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_ctrl_pkg::instr_t   instr,
  input  logic                  instr_valid,
  input  logic                  stall,
  input  logic                  br_eq,
  input  logic                  br_lt,
  output logic                  x_valid,
  output rv_ctrl_pkg::alu_op_t  alu_op,
  output rv_ctrl_pkg::a_sel_t   a_sel,
  output rv_ctrl_pkg::b_sel_t   b_sel,
  output rv_ctrl_pkg::imm_fmt_t imm_fmt,
  output logic                  br_un,
  output rv_ctrl_pkg::pc_sel_t  pc_sel,
  output logic                  w_valid,
  output logic                  rf_we,
  output rv_ctrl_pkg::wb_sel_t  wb_sel,
  output rv_ctrl_pkg::ldx_t     ldx
);

  import rv_ctrl_pkg::*;

  logic    d_valid;
  instr_t  d_instr;
  x_ctrl_t dec_ctrl;
  x_ctrl_t x_ctrl;
  w_ctrl_t w_ctrl;
  logic    kill;

  pipe_slot #(.payload_t(instr_t)) i_d_slot (
    .clk(clk), .rst(rst),
    .in_valid(instr_valid), .in_payload(instr),
    .hold(stall), .kill(kill),
    .out_valid(d_valid), .out_payload(d_instr)
  );

  instr_decoder i_decoder (
    .instr(d_instr),
    .ctrl (dec_ctrl)
  );

  pipe_slot #(.payload_t(x_ctrl_t)) i_x_slot (
    .clk(clk), .rst(rst),
    .in_valid(d_valid), .in_payload(dec_ctrl),
    .hold(stall), .kill(kill),
    .out_valid(x_valid), .out_payload(x_ctrl)
  );

  branch_resolver i_resolver (
    .x_valid(x_valid), .x_ctrl(x_ctrl),
    .br_eq(br_eq), .br_lt(br_lt), .stall(stall),
    .pc_sel(pc_sel), .kill(kill)
  );

  // Stall drops a bubble into writeback, no hold there
  pipe_slot #(.payload_t(w_ctrl_t)) i_w_slot (
    .clk(clk), .rst(rst),
    .in_valid(x_valid), .in_payload(x_ctrl.w),
    .hold(1'b0), .kill(stall),
    .out_valid(w_valid), .out_payload(w_ctrl)
  );

  assign alu_op  = x_ctrl.alu_op;
  assign a_sel   = x_ctrl.a_sel;
  assign b_sel   = x_ctrl.b_sel;
  assign imm_fmt = x_ctrl.imm_fmt;
  assign br_un   = x_ctrl.br_un;
  assign rf_we   = w_ctrl.rf_we;
  assign wb_sel  = w_ctrl.wb_sel;
  assign ldx     = w_ctrl.ldx;

endmodule

//--- test/rv_ctrl_properties.sv
// Concurrent checks on the rv_ctrl_top control outputs, attached to every DUT instance by bind
`timescale 1ns/10ps

module rv_ctrl_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 stall,
  input logic                 kill,
  input logic                 x_valid,
  input rv_ctrl_pkg::pc_sel_t pc_sel,
  input logic                 w_valid,
  input logic                 rf_we,
  input logic [18:0]          outs    // All top-level outputs packed together
);

  import rv_ctrl_pkg::*;

  a_we_needs_valid: assert property (@(posedge clk) disable iff (rst) rf_we |-> w_valid)
    else $error("rf_we is high while w_valid is low");

  a_kill_in_execute: assert property (@(posedge clk) disable iff (rst)
    kill |-> (x_valid && !stall))
    else $error("kill raised without a valid unstalled execute entry");

  // Redirect must also empty the execute slot on the next cycle
  a_redirect_kills: assert property (@(posedge clk) disable iff (rst)
    (pc_sel == pc_alu) |-> kill ##1 !x_valid)
    else $error("pc_sel selects the alu target without killing the younger execute entry");

  a_outputs_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(outs))
    else $error("a control output is unknown after reset");

endmodule

bind rv_ctrl_top rv_ctrl_properties i_props (
  .clk(clk), .rst(rst), .stall(stall), .kill(kill), .x_valid(x_valid),
  .pc_sel(pc_sel), .w_valid(w_valid), .rf_we(rf_we),
  .outs({x_valid, alu_op, a_sel, b_sel, imm_fmt, br_un, pc_sel, w_valid, rf_we, wb_sel, ldx})
);

//--- test/tb_rv_ctrl.sv
// Directed testbench for rv_ctrl_top, compiled with the design through the project file list
`timescale 1ns/10ps

module tb_rv_ctrl;

  import rv_ctrl_pkg::*;

  localparam int n_test_instr    = 86;    // Instructions presented by all tests
  localparam int watchdog_cycles = 40 * n_test_instr + 200;

  logic     clk;
  logic     rst;
  instr_t   instr;
  logic     instr_valid;
  logic     stall;
  logic     br_eq;
  logic     br_lt;
  logic     x_valid;
  alu_op_t  alu_op;
  a_sel_t   a_sel;
  b_sel_t   b_sel;
  imm_fmt_t imm_fmt;
  logic     br_un;
  pc_sel_t  pc_sel;
  logic     w_valid;
  logic     rf_we;
  wb_sel_t  wb_sel;
  ldx_t     ldx;
  int       checks;
  int       mismatches;

  rv_ctrl_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic instr_t make_instr(logic [6:0] op, logic [2:0] f3, logic b30);
    instr_t ins;
    ins        = $urandom;                // Register fields and immediates
    ins[6:0]   = op;
    ins[14:12] = f3;
    ins[30]    = b30;
    return ins;
  endfunction

  function automatic alu_op_t base_alu(logic [2:0] f3);
    case (f3)
      3'd0:    return alu_add;
      3'd1:    return alu_sll;
      3'd2:    return alu_slt;
      3'd3:    return alu_sltu;
      3'd4:    return alu_xor;
      3'd5:    return alu_srl;
      3'd6:    return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // Expected execute bundle from the RV32I decode rules
  function automatic x_ctrl_t expected_ctrl(instr_t ins);
    x_ctrl_t    c;
    logic [2:0] f3;
    c  = '0;
    f3 = ins[14:12];
    case (ins[6:0])
      op_r: begin
        c.alu_op = base_alu(f3);
        if (ins[30] && f3 == 3'd0) c.alu_op = alu_sub;
        if (ins[30] && f3 == 3'd5) c.alu_op = alu_sra;
        c.w = '{1'b1, wb_alu, ldx_word};
      end
      op_imm: begin
        c.alu_op  = (ins[30] && f3 == 3'd5) ? alu_sra : base_alu(f3);  // Only srai uses bit 30
        c.b_sel   = b_imm;
        c.imm_fmt = imm_i;
        c.w       = '{1'b1, wb_alu, ldx_word};
      end
      op_load: begin
        c.b_sel   = b_imm;
        c.imm_fmt = imm_i;
        c.w       = '{1'b1, wb_mem, f3 == 3'd0 ? ldx_bs : f3 == 3'd1 ? ldx_hs :
                     f3 == 3'd4 ? ldx_bu : f3 == 3'd5 ? ldx_hu : ldx_word};
      end
      op_store: begin
        c.b_sel   = b_imm;
        c.imm_fmt = imm_s;
      end
      op_branch: begin
        c.a_sel   = a_pc;
        c.b_sel   = b_imm;
        c.imm_fmt = imm_b;
        c.br_un   = (f3 == f3_bltu) || (f3 == f3_bgeu);
        c.br_kind = br_branch;
        c.funct3  = f3;
      end
      op_jal: begin
        c.a_sel   = a_pc;
        c.b_sel   = b_imm;
        c.imm_fmt = imm_j;
        c.br_kind = br_jump;
        c.w       = '{1'b1, wb_pc_plus4, ldx_word};
      end
      op_jalr: begin
        c.b_sel   = b_imm;
        c.imm_fmt = imm_i;
        c.br_kind = br_jump;
        c.w       = '{1'b1, wb_pc_plus4, ldx_word};
      end
      op_auipc: begin
        c.a_sel   = a_pc;
        c.b_sel   = b_imm;
        c.imm_fmt = imm_u;
        c.w       = '{1'b1, wb_alu, ldx_word};
      end
      op_lui: begin
        c.b_sel   = b_imm;
        c.imm_fmt = imm_u;
        c.w       = '{1'b1, wb_alu, ldx_word};
      end
      default: c = '0;
    endcase
    return c;
  endfunction

  function automatic logic expected_redirect(x_ctrl_t c, logic eq, logic lt);
    if (c.br_kind == br_jump) return 1'b1;
    if (c.br_kind != br_branch) return 1'b0;
    case (c.funct3)
      f3_beq:          return eq;
      f3_bne:          return !eq;
      f3_blt, f3_bltu: return lt;
      f3_bge, f3_bgeu: return !lt;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic report(string sig, string ctx, logic [31:0] exp, logic [31:0] act);
    mismatches++;
    $display("MISMATCH at %0t: %s (%s) expected %0h got %0h", $time, sig, ctx, exp, act);
  endtask

  task automatic check_bit(string sig, string ctx, logic act, logic exp);
    checks++;
    if (act !== exp) report(sig, ctx, 32'(exp), 32'(act));
  endtask

  task automatic check_x(string ctx, x_ctrl_t exp);
    checks++;
    if (alu_op !== exp.alu_op) report("alu_op", ctx, 32'(exp.alu_op), 32'(alu_op));
    if (a_sel !== exp.a_sel) report("a_sel", ctx, 32'(exp.a_sel), 32'(a_sel));
    if (b_sel !== exp.b_sel) report("b_sel", ctx, 32'(exp.b_sel), 32'(b_sel));
    if (imm_fmt !== exp.imm_fmt) report("imm_fmt", ctx, 32'(exp.imm_fmt), 32'(imm_fmt));
    if (br_un !== exp.br_un) report("br_un", ctx, 32'(exp.br_un), 32'(br_un));
  endtask

  task automatic check_w(string ctx, w_ctrl_t exp);
    checks++;
    if (rf_we !== exp.rf_we) report("rf_we", ctx, 32'(exp.rf_we), 32'(rf_we));
    if (wb_sel !== exp.wb_sel) report("wb_sel", ctx, 32'(exp.wb_sel), 32'(wb_sel));
    if (ldx !== exp.ldx) report("ldx", ctx, 32'(exp.ldx), 32'(ldx));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One instruction through all three slots, flags set while it executes
  task automatic run_one(string ctx, instr_t ins, logic eq, logic lt);
    x_ctrl_t exp;
    logic    taken;
    exp   = expected_ctrl(ins);
    taken = expected_redirect(exp, eq, lt);
    next_cycle();
    instr       = ins;
    instr_valid = 1'b1;
    next_cycle();
    instr_valid = 1'b0;
    instr       = $urandom;
    next_cycle();
    br_eq = eq;
    br_lt = lt;
    @(negedge clk);
    check_bit("x_valid", ctx, x_valid, 1'b1);
    check_x(ctx, exp);
    check_bit("pc_sel", ctx, pc_sel, taken);
    check_bit("kill", ctx, i_dut.kill, taken);
    next_cycle();
    br_eq = 1'b0;
    br_lt = 1'b0;
    @(negedge clk);
    check_bit("w_valid", ctx, w_valid, 1'b1);
    check_w(ctx, exp.w);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_bit("x_valid", "reset", x_valid, 1'b0);
    check_bit("w_valid", "reset", w_valid, 1'b0);
    check_bit("rf_we", "reset", rf_we, 1'b0);
    check_bit("kill", "reset", i_dut.kill, 1'b0);
    check_bit("pc_sel", "reset", pc_sel, 1'b0);
  endtask

  task automatic test_alu();
    for (int f = 0; f < 8; f++) begin
      for (int b = 0; b < 2; b++) begin
        run_one($sformatf("R f3=%0d b30=%0d", f, b), make_instr(op_r, f[2:0], b[0]), 1'b0, 1'b0);
        run_one($sformatf("I f3=%0d b30=%0d", f, b), make_instr(op_imm, f[2:0], b[0]), 1'b0,
                1'b0);
      end
    end
  endtask

  task automatic test_formats();
    for (int f = 0; f < 6; f++) begin
      if (f == 3) continue;
      run_one($sformatf("load f3=%0d", f), make_instr(op_load, f[2:0], 1'($urandom)), 1'b0, 1'b0);
    end
    for (int f = 0; f < 3; f++) begin
      run_one("store", make_instr(op_store, f[2:0], 1'($urandom)), 1'b0, 1'b0);
    end
    run_one("jal", make_instr(op_jal, 3'($urandom), 1'($urandom)), 1'b0, 1'b0);
    run_one("jalr", make_instr(op_jalr, 3'd0, 1'($urandom)), 1'b0, 1'b0);
    run_one("auipc", make_instr(op_auipc, 3'($urandom), 1'($urandom)), 1'b0, 1'b0);
    run_one("lui", make_instr(op_lui, 3'($urandom), 1'($urandom)), 1'b0, 1'b0);
    run_one("illegal", make_instr(7'b0001111, 3'd0, 1'b0), 1'b0, 1'b0);   // fence
    run_one("illegal", make_instr(7'b1110011, 3'd0, 1'b0), 1'b0, 1'b0);   // system
    run_one("illegal", make_instr(7'b0000000, 3'd0, 1'b0), 1'b0, 1'b0);
  endtask

  task automatic test_branches();
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;       // Reserved branch encodings
      for (int e = 0; e < 2; e++) begin
        for (int l = 0; l < 2; l++) begin
          run_one($sformatf("branch f3=%0d eq=%0d lt=%0d", f, e, l),
                  make_instr(op_branch, f[2:0], 1'($urandom)), e[0], l[0]);
        end
      end
    end
  endtask

  // Two instructions behind a redirect are dropped, the third executes
  task automatic test_kill();
    instr_t xfer [3];
    x_ctrl_t exp_c;
    instr_t  ins_c;
    xfer[0] = make_instr(op_branch, f3_beq, 1'b0);
    xfer[1] = make_instr(op_jal, 3'($urandom), 1'b0);
    xfer[2] = make_instr(op_jalr, 3'd0, 1'b0);
    for (int t = 0; t < 3; t++) begin
      ins_c = make_instr(op_lui, 3'($urandom), 1'($urandom));
      exp_c = expected_ctrl(ins_c);
      next_cycle();
      instr       = xfer[t];
      instr_valid = 1'b1;
      next_cycle();
      instr = make_instr(op_r, 3'd0, 1'b0);
      next_cycle();
      instr = make_instr(op_r, 3'd4, 1'b0);
      br_eq = 1'b1;
      @(negedge clk);
      check_bit("kill", "redirect", i_dut.kill, 1'b1);
      next_cycle();
      instr = ins_c;
      br_eq = 1'b0;
      @(negedge clk);
      check_bit("x_valid", "first killed", x_valid, 1'b0);
      next_cycle();
      instr_valid = 1'b0;
      @(negedge clk);
      check_bit("x_valid", "second killed", x_valid, 1'b0);
      next_cycle();
      @(negedge clk);
      check_bit("x_valid", "after kill", x_valid, 1'b1);
      check_x("after kill", exp_c);
    end
  endtask

  task automatic test_stall();
    instr_t  ins [3];
    x_ctrl_t exp [3];
    ins[0] = make_instr(op_r, 3'd0, 1'b1);
    ins[1] = make_instr(op_load, 3'd2, 1'b0);
    ins[2] = make_instr(op_lui, 3'($urandom), 1'b0);
    for (int i = 0; i < 3; i++) exp[i] = expected_ctrl(ins[i]);
    next_cycle();
    instr       = ins[0];
    instr_valid = 1'b1;
    next_cycle();
    instr = ins[1];
    next_cycle();
    instr = ins[2];                      // Held at the input until accepted
    stall = 1'b1;
    for (int s = 0; s < 5; s++) begin
      if (s == 4) stall = 1'b0;
      @(negedge clk);
      check_x("stall hold", exp[0]);
      check_bit("x_valid", "stall hold", x_valid, 1'b1);
      // Writeback only sees the stall from the first stalled edge on
      if (s > 0) check_bit("w_valid", "stall hold", w_valid, 1'b0);
      next_cycle();
    end
    instr_valid = 1'b0;
    for (int i = 1; i < 4; i++) begin
      @(negedge clk);
      if (i < 3) check_x("resume", exp[i]);
      check_bit("x_valid", "resume", x_valid, i < 3);
      check_bit("w_valid", "resume", w_valid, 1'b1);
      check_w("resume", exp[i-1].w);
      next_cycle();
    end
  endtask

  initial begin
    rst         = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    stall       = 1'b0;
    br_eq       = 1'b0;
    br_lt       = 1'b0;
    checks      = 0;
    mismatches  = 0;
    void'($urandom(32'hf1b0_c81c));
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_alu();
    test_formats();
    test_branches();
    test_kill();
    test_stall();
    $display("Checks run: %0d, mismatches: %0d", checks, mismatches);
    if (mismatches == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- rv_ctrl.f
rtl/rv_ctrl_pkg.sv
rtl/pipe_slot.sv
rtl/instr_decoder.sv
rtl/branch_resolver.sv
rtl/rv_ctrl_top.sv
test/rv_ctrl_properties.sv
test/tb_rv_ctrl.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_ctrl -f rv_ctrl.f \
  -o sim_rv_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_rv_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
  echo "Result: FAIL"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "Result: no verdict found in sim.log"
  exit 1
fi
echo "Result: PASS"
exit 0
